// File: cim_aes.f
common/cim_aes_pkg.sv
round_sequencer/round_sequencer.sv
logic/slice_gather.sv
logic/cim_address_driver.sv
logic/cim_aes_top.sv
test/cim_aes_assert.sv
test/tb_cim_aes.sv

// File: Makefile
# Verilator build and run for the CIM AES round controller

TOP = tb_cim_aes

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f cim_aes.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// File: test/tb_cim_aes.sv
// runs the default 11 groups; rio is random and stands in for the CIM macro read port
`timescale 1ns/100ps

module tb_cim_aes;

    localparam int NUM_GROUPS = 11;
    localparam int NUM_OPS    = 8;
    localparam int OP_CYCLES  = 110;
    localparam int TIMEOUT    = NUM_OPS * OP_CYCLES * 4 + 200;

    logic                                         CLK;
    logic                                         rst;
    logic                                         en;
    logic                                         start;
    cim_aes_pkg::block_t                          din;
    cim_aes_pkg::lane_bytes_t                     rio;
    cim_aes_pkg::slice_t                          wr_bits;
    logic                                         busy;
    cim_aes_pkg::block_t                          dout;
    logic                                         dvld;
    cim_aes_pkg::demux_t [cim_aes_pkg::LANES-1:0] demux_addr;
    cim_aes_pkg::row_t   [cim_aes_pkg::LANES-1:0] row_addr;

    // reference model
    cim_aes_pkg::phase_t m_phase;
    int                  m_slot;
    int                  m_group;
    cim_aes_pkg::block_t m_state;
    cim_aes_pkg::block_t m_lookup;
    cim_aes_pkg::block_t m_dout;
    logic                m_busy;
    logic                m_dvld;

    int     since_start;
    int     ops_done;
    int     cycles;
    logic   prev_busy;
    integer seed;

    cim_aes_top #(
        .NUM_GROUPS (NUM_GROUPS)
    ) UUT (
        .CLK        (CLK),
        .rst        (rst),
        .en         (en),
        .start      (start),
        .din        (din),
        .rio        (rio),
        .wr_bits    (wr_bits),
        .busy       (busy),
        .dout       (dout),
        .dvld       (dvld),
        .demux_addr (demux_addr),
        .row_addr   (row_addr)
    );

    always #10 CLK = ~CLK;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // lane 0 is the top byte of a 128-bit word
    function automatic cim_aes_pkg::byte_t lane_of(input cim_aes_pkg::block_t v, input int n);
        return v[(cim_aes_pkg::LANES - 1 - n) * 8 +: 8];
    endfunction

    // groups 0..10 cycle 7,6,5,4 on demux and step the row every four groups
    function automatic cim_aes_pkg::demux_t group_demux(input int g);
        if (g > 10) begin
            return 3'd0;
        end
        return cim_aes_pkg::demux_t'(7 - g % 4);
    endfunction

    function automatic cim_aes_pkg::row_t group_row(input int g);
        if (g > 10) begin
            return 6'd0;
        end
        return cim_aes_pkg::row_t'(g / 4);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_slice(input string name, input cim_aes_pkg::slice_t got,
                               input cim_aes_pkg::slice_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_demux(input int lane, input cim_aes_pkg::demux_t got,
                               input cim_aes_pkg::demux_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: demux_addr[%0d] got %h expected %h",
                               $time, lane, got, exp));
        end
    endtask

    task automatic check_row(input int lane, input cim_aes_pkg::row_t got,
                             input cim_aes_pkg::row_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: row_addr[%0d] got %h expected %h",
                               $time, lane, got, exp));
        end
    endtask

    task automatic check_block(input string name, input cim_aes_pkg::block_t got,
                               input cim_aes_pkg::block_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // model update, one enabled edge
    // ------------------------------------------------------------
    task automatic model_step();
        cim_aes_pkg::byte_t even_b;
        cim_aes_pkg::byte_t odd_b;
        cim_aes_pkg::byte_t lane_b;
        if (en) begin
            if (m_busy) begin
                since_start++;
            end
            m_dvld = 1'b0;
            case (m_phase)
                cim_aes_pkg::PH_IDLE: begin
                    if (start) begin
                        m_phase     = cim_aes_pkg::PH_READ;
                        m_slot      = 0;
                        m_group     = 0;
                        m_busy      = 1'b1;
                        since_start = 0;
                    end
                end
                cim_aes_pkg::PH_READ: begin
                    // bit plane 7-slot, lanes 0..7 then lanes 8..15
                    for (int i = 0; i < 8; i++) begin
                        lane_b    = lane_of(rio, i);
                        even_b[i] = lane_b[7 - m_slot];
                        lane_b    = lane_of(rio, 8 + i);
                        odd_b[i]  = lane_b[7 - m_slot];
                    end
                    m_lookup[(15 - 2 * m_slot) * 8 +: 8] = even_b;
                    m_lookup[(14 - 2 * m_slot) * 8 +: 8] = odd_b;
                    if (m_slot == cim_aes_pkg::SLOTS - 1) begin
                        m_slot  = 0;
                        m_phase = cim_aes_pkg::PH_LOOKUP;
                    end else begin
                        m_slot++;
                    end
                end
                cim_aes_pkg::PH_LOOKUP: begin
                    if (m_group == NUM_GROUPS - 1) begin
                        m_dout  = m_lookup;
                        m_dvld  = 1'b1;
                        m_phase = cim_aes_pkg::PH_OUT;
                    end else begin
                        m_phase = cim_aes_pkg::PH_MIX;
                    end
                end
                cim_aes_pkg::PH_MIX: begin
                    m_state = rio;
                    m_group++;
                    m_phase = cim_aes_pkg::PH_READ;
                end
                default: begin
                    m_phase = cim_aes_pkg::PH_IDLE;
                    m_busy  = 1'b0;
                    ops_done++;
                end
            endcase
        end
    endtask

    task automatic drive_inputs();
        cim_aes_pkg::block_t d;
        cim_aes_pkg::block_t r;
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        din <= d;
        rio <= r;
        en  <= (($random(seed) & 3) != 0);
        // rare start while busy, frequent start when idle
        if (m_busy) begin
            start <= (($random(seed) & 7) == 0);
        end else begin
            start <= (($random(seed) & 1) == 0);
        end
    endtask

    // ------------------------------------------------------------
    // output checks, at the falling edge
    // ------------------------------------------------------------
    task automatic check_outputs();
        cim_aes_pkg::block_t src;
        cim_aes_pkg::slice_t exp_wr;
        cim_aes_pkg::byte_t  b;
        cim_aes_pkg::demux_t exp_d;
        cim_aes_pkg::row_t   exp_r;
        exp_wr = '0;
        if (m_phase == cim_aes_pkg::PH_READ) begin
            src    = (m_group == 0) ? din : m_state;
            exp_wr = src[(cim_aes_pkg::SLOTS - 1 - m_slot) * 16 +: 16];
        end
        check_slice("wr_bits", wr_bits, exp_wr);
        for (int j = 0; j < cim_aes_pkg::LANES; j++) begin
            exp_d = '0;
            exp_r = '0;
            if (m_phase == cim_aes_pkg::PH_READ) begin
                exp_d = group_demux(m_group);
                exp_r = group_row(m_group);
            end else if (m_phase == cim_aes_pkg::PH_LOOKUP) begin
                b     = lane_of(m_lookup, j);
                exp_d = {1'b0, b[7:6]};
                exp_r = b[5:0];
            end
            check_demux(j, demux_addr[j], exp_d);
            check_row(j, row_addr[j], exp_r);
        end
        check_block("dout", dout, m_dout);
        if (dvld) begin
            check_count("enabled cycles to dvld", since_start, OP_CYCLES - 1);
        end
        if (prev_busy && !busy) begin
            check_count("enabled cycles to busy fall", since_start, OP_CYCLES);
        end
        check_flag("dvld", dvld, m_dvld);
        check_flag("busy", busy, m_busy);
        prev_busy = busy;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed        = 32'h0de81527;
        CLK         = 1'b0;
        rst         = 1'b1;
        en          = 1'b0;
        start       = 1'b0;
        din         = '0;
        rio         = '0;
        m_phase     = cim_aes_pkg::PH_IDLE;
        m_slot      = 0;
        m_group     = 0;
        m_state     = '0;
        m_lookup    = '0;
        m_dout      = '0;
        m_busy      = 1'b0;
        m_dvld      = 1'b0;
        since_start = 0;
        ops_done    = 0;
        cycles      = 0;
        prev_busy   = 1'b0;

        // one check inside reset, released on the third rising edge
        @(negedge CLK);
        check_outputs();
        repeat (3) @(posedge CLK);
        rst <= 1'b0;

        while (ops_done < NUM_OPS && cycles < TIMEOUT) begin
            drive_inputs();
            @(negedge CLK);
            check_outputs();
            @(posedge CLK);
            model_step();
            cycles++;
        end
        @(negedge CLK);
        check_outputs();

        if (ops_done == NUM_OPS) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run($sformatf("timeout: %0d of %0d operations done after %0d cycles",
                               ops_done, NUM_OPS, cycles));
        end
    end

endmodule

// File: test/cim_aes_assert.sv
// checks are sampled on CLK and held off during rst; en low cycles keep dvld as it was
`timescale 1ns/100ps

module cim_aes_assert (
    input logic                CLK,
    input logic                rst,
    input logic                en,
    input logic                busy,
    input logic                dvld,
    input cim_aes_pkg::slice_t wr_bits
);

    // ------------------------------------------------------------
    // handshake properties
    // ------------------------------------------------------------
    property dvld_within_busy;
        @(posedge CLK) disable iff (rst) dvld |-> busy;
    endproperty

    // one enabled cycle wide
    property dvld_single_pulse;
        @(posedge CLK) disable iff (rst) (dvld && en) |=> !dvld;
    endproperty

    property wr_bits_quiet_when_idle;
        @(posedge CLK) disable iff (rst) !busy |-> (wr_bits == '0);
    endproperty

    a_dvld_within_busy: assert property (dvld_within_busy)
        else $error("dvld high while busy is low");

    a_dvld_single_pulse: assert property (dvld_single_pulse)
        else $error("dvld high on two enabled cycles in a row");

    a_wr_bits_quiet: assert property (wr_bits_quiet_when_idle)
        else $error("wr_bits nonzero while not busy");

endmodule

bind cim_aes_top cim_aes_assert u_cim_aes_assert (
    .CLK     (CLK),
    .rst     (rst),
    .en      (en),
    .busy    (busy),
    .dvld    (dvld),
    .wr_bits (wr_bits)
);

// File: logic/cim_aes_top.sv
// NUM_GROUPS from 2 to 16; the CIM macro is external and answers on rio in the same cycle
`timescale 1ns/100ps

module cim_aes_top #(
    parameter int NUM_GROUPS = 11
) (
    input  logic                                         CLK,
    input  logic                                         rst,
    input  logic                                         en,
    input  logic                                         start,
    input  cim_aes_pkg::block_t                          din,
    input  cim_aes_pkg::lane_bytes_t                     rio,
    output cim_aes_pkg::slice_t                          wr_bits,
    output logic                                         busy,
    output cim_aes_pkg::block_t                          dout,
    output logic                                         dvld,
    output cim_aes_pkg::demux_t [cim_aes_pkg::LANES-1:0] demux_addr,
    output cim_aes_pkg::row_t   [cim_aes_pkg::LANES-1:0] row_addr
);

    // ------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------
    cim_aes_pkg::phase_t      phase;
    cim_aes_pkg::slot_t       slot;
    cim_aes_pkg::group_t      group;
    logic                     final_lookup;
    cim_aes_pkg::lane_bytes_t lookup;

    round_sequencer #(
        .NUM_GROUPS (NUM_GROUPS)
    ) u_round_sequencer (
        .CLK          (CLK),
        .rst          (rst),
        .en           (en),
        .start        (start),
        .din          (din),
        .rio          (rio),
        .phase        (phase),
        .slot         (slot),
        .group        (group),
        .final_lookup (final_lookup),
        .wr_bits      (wr_bits),
        .busy         (busy)
    );

    slice_gather u_slice_gather (
        .CLK    (CLK),
        .rst    (rst),
        .en     (en),
        .phase  (phase),
        .slot   (slot),
        .rio    (rio),
        .lookup (lookup)
    );

    cim_address_driver u_cim_address_driver (
        .CLK          (CLK),
        .rst          (rst),
        .en           (en),
        .phase        (phase),
        .group        (group),
        .final_lookup (final_lookup),
        .lookup       (lookup),
        .demux_addr   (demux_addr),
        .row_addr     (row_addr),
        .dout         (dout),
        .dvld         (dvld)
    );

endmodule

// File: logic/cim_address_driver.sv
// demux_addr and row_addr are indexed by lane number; dout keeps lane 0 in its top byte
`timescale 1ns/100ps

module cim_address_driver (
    input  logic                                         CLK,
    input  logic                                         rst,
    input  logic                                         en,
    input  cim_aes_pkg::phase_t                          phase,
    input  cim_aes_pkg::group_t                          group,
    input  logic                                         final_lookup,
    input  cim_aes_pkg::lane_bytes_t                     lookup,
    output cim_aes_pkg::demux_t [cim_aes_pkg::LANES-1:0] demux_addr,
    output cim_aes_pkg::row_t   [cim_aes_pkg::LANES-1:0] row_addr,
    output cim_aes_pkg::block_t                          dout,
    output logic                                         dvld
);

    localparam int LANES = cim_aes_pkg::LANES;

    cim_aes_pkg::demux_t group_demux;
    cim_aes_pkg::row_t   group_row;

    assign group_demux = cim_aes_pkg::demux_code(group);
    assign group_row   = cim_aes_pkg::row_code(group);

    // ------------------------------------------------------------
    // per-lane address decode
    // ------------------------------------------------------------
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            demux_addr[j] = '0;
            row_addr[j]   = '0;
            case (phase)
                cim_aes_pkg::PH_READ: begin
                    demux_addr[j] = group_demux;
                    row_addr[j]   = group_row;
                end
                cim_aes_pkg::PH_LOOKUP: begin
                    // top two bits pick the demux, low six the row
                    demux_addr[j] = {1'b0, lookup[LANES - 1 - j][7:6]};
                    row_addr[j]   = lookup[LANES - 1 - j][5:0];
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // result register and valid pulse
    // ------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
            dvld <= 1'b0;
        end else if (en) begin
            dvld <= final_lookup;
            if (final_lookup) begin
                dout <= lookup;
            end
        end
    end

endmodule

// File: logic/slice_gather.sv
// bit plane 7-k of all lanes is taken in read slot k; bytes hold outside the read phase
`timescale 1ns/100ps

module slice_gather (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     en,
    input  cim_aes_pkg::phase_t      phase,
    input  cim_aes_pkg::slot_t       slot,
    input  cim_aes_pkg::lane_bytes_t rio,
    output cim_aes_pkg::lane_bytes_t lookup
);

    localparam int LANES = cim_aes_pkg::LANES;
    localparam int HALF  = cim_aes_pkg::LANES / 2;

    // storage index of lookup bytes 2k and 2k+1
    int                 even_idx;
    int                 odd_idx;
    cim_aes_pkg::slot_t plane;

    // ------------------------------------------------------------
    // index decode for the current slot
    // ------------------------------------------------------------
    assign even_idx = LANES - 1 - 2 * int'(slot);
    assign odd_idx  = LANES - 2 - 2 * int'(slot);
    assign plane    = cim_aes_pkg::slot_t'(cim_aes_pkg::SLOTS - 1) - slot;

    // ------------------------------------------------------------
    // transpose buffer
    // ------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            lookup <= '0;
        end else if (en && phase == cim_aes_pkg::PH_READ) begin
            for (int i = 0; i < HALF; i++) begin
                // lanes 0..7 feed the even byte
                lookup[even_idx][i] <= rio[LANES - 1 - i][plane];
                // lanes 8..15 feed the odd byte
                lookup[odd_idx][i]  <= rio[HALF - 1 - i][plane];
            end
        end
    end

endmodule

// File: round_sequencer/round_sequencer.sv
// start is taken only in idle with en high; en low freezes every register here
`timescale 1ns/100ps

module round_sequencer #(
    parameter int NUM_GROUPS = 11
) (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     en,
    input  logic                     start,
    input  cim_aes_pkg::block_t      din,
    input  cim_aes_pkg::lane_bytes_t rio,
    output cim_aes_pkg::phase_t      phase,
    output cim_aes_pkg::slot_t       slot,
    output cim_aes_pkg::group_t      group,
    output logic                     final_lookup,
    output cim_aes_pkg::slice_t      wr_bits,
    output logic                     busy
);

    localparam cim_aes_pkg::group_t LAST_GROUP = cim_aes_pkg::group_t'(NUM_GROUPS - 1);
    localparam cim_aes_pkg::slot_t  LAST_SLOT  = cim_aes_pkg::slot_t'(cim_aes_pkg::SLOTS - 1);
    localparam int                  SLICE_W    = $bits(cim_aes_pkg::slice_t);

    cim_aes_pkg::phase_t next_phase;
    cim_aes_pkg::block_t round_state;
    cim_aes_pkg::block_t src;

    // ------------------------------------------------------------
    // phase FSM
    // ------------------------------------------------------------
    always_comb begin
        next_phase = phase;
        case (phase)
            cim_aes_pkg::PH_IDLE: begin
                if (start) begin
                    next_phase = cim_aes_pkg::PH_READ;
                end
            end
            cim_aes_pkg::PH_READ: begin
                if (slot == LAST_SLOT) begin
                    next_phase = cim_aes_pkg::PH_LOOKUP;
                end
            end
            cim_aes_pkg::PH_LOOKUP: begin
                // last group skips the mix and goes to output
                if (group == LAST_GROUP) begin
                    next_phase = cim_aes_pkg::PH_OUT;
                end else begin
                    next_phase = cim_aes_pkg::PH_MIX;
                end
            end
            cim_aes_pkg::PH_MIX: next_phase = cim_aes_pkg::PH_READ;
            cim_aes_pkg::PH_OUT: next_phase = cim_aes_pkg::PH_IDLE;
            default:             next_phase = cim_aes_pkg::PH_IDLE;
        endcase
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase <= cim_aes_pkg::PH_IDLE;
            busy  <= 1'b0;
        end else if (en) begin
            phase <= next_phase;
            if (phase == cim_aes_pkg::PH_IDLE && start) begin
                busy <= 1'b1;
            end else if (phase == cim_aes_pkg::PH_OUT) begin
                busy <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // slot and group counters
    // ------------------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            slot  <= '0;
            group <= '0;
        end else if (en) begin
            case (phase)
                cim_aes_pkg::PH_IDLE: begin
                    slot  <= '0;
                    group <= '0;
                end
                cim_aes_pkg::PH_READ: begin
                    // wraps to 0 after the last slot
                    slot <= slot + 1'b1;
                end
                cim_aes_pkg::PH_MIX: begin
                    group <= group + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign final_lookup = (phase == cim_aes_pkg::PH_LOOKUP) && (group == LAST_GROUP);

    // round state, captured from the macro at the end of each group
    always_ff @(posedge CLK) begin
        if (en && phase == cim_aes_pkg::PH_MIX) begin
            round_state <= rio;
        end
    end

    // ------------------------------------------------------------
    // write slice, MSB first
    // ------------------------------------------------------------
    assign src = (group == '0) ? din : round_state;

    always_comb begin
        wr_bits = '0;
        if (phase == cim_aes_pkg::PH_READ) begin
            wr_bits = src[(int'(LAST_SLOT) - int'(slot)) * SLICE_W +: SLICE_W];
        end
    end

endmodule

// File: common/cim_aes_pkg.sv
// shared types for the CIM AES controller; group codes are defined for groups 0..10 only
package cim_aes_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------
    localparam int LANES = 16;
    localparam int SLOTS = 8;

    // ------------------------------------------------------------
    // data types
    // ------------------------------------------------------------
    typedef logic [7:0] byte_t;

    // lane 0 sits in the top byte, index LANES-1
    typedef byte_t [LANES-1:0] lane_bytes_t;

    typedef logic [127:0] block_t;
    typedef logic [15:0]  slice_t;
    typedef logic [2:0]   demux_t;
    typedef logic [5:0]   row_t;
    typedef logic [2:0]   slot_t;
    typedef logic [3:0]   group_t;

    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_READ   = 3'd1,
        PH_LOOKUP = 3'd2,
        PH_MIX    = 3'd3,
        PH_OUT    = 3'd4
    } phase_t;

    // ------------------------------------------------------------
    // per-group macro address codes used while reading
    // ------------------------------------------------------------
    function automatic demux_t demux_code(input group_t g);
        case (g)
            4'd0, 4'd4, 4'd8:  return 3'd7;
            4'd1, 4'd5, 4'd9:  return 3'd6;
            4'd2, 4'd6, 4'd10: return 3'd5;
            4'd3, 4'd7:        return 3'd4;
            default:           return 3'd0;
        endcase
    endfunction

    function automatic row_t row_code(input group_t g);
        case (g)
            4'd0, 4'd1, 4'd2, 4'd3: return 6'd0;
            4'd4, 4'd5, 4'd6, 4'd7: return 6'd1;
            4'd8, 4'd9, 4'd10:      return 6'd2;
            default:                return 6'd0;
        endcase
    endfunction

endpackage
